// File: bench/spu_asserts.sv
`timescale 1ns/1ps

module spu_asserts import spu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic i_cmd_valid,
    input logic o_cmd_credit,
    input logic o_rsp_valid,
    input logic i_rsp_credit
);

    int outstanding;                                    // Commands not yet credited back
    int held;                                           // Output credits inside the DUT
    int fail_count = 0;                                 // Failed assertions so far

    always @(posedge clk) begin
        if (reset) begin
            outstanding <= 0;
            held        <= RSP_CREDITS;                 // Receiver starts empty
        end else begin
            outstanding <= outstanding + int'(i_cmd_valid) - int'(o_cmd_credit);
            held        <= held - int'(o_rsp_valid) + int'(i_rsp_credit);
        end
    end

    credit_quiet_in_reset: assert property (@(posedge clk) reset |=> !o_cmd_credit)
        else begin
            $error("o_cmd_credit high during reset");
            fail_count++;
        end

    send_needs_credit: assert property (@(posedge clk) disable iff (reset)
        o_rsp_valid |-> held > 0)
        else begin
            $error("o_rsp_valid with no output credit held");
            fail_count++;
        end

    queue_never_overrun: assert property (@(posedge clk) disable iff (reset)
        outstanding <= CMD_CREDITS)
        else begin
            $error("outstanding commands %0d exceed the queue depth", outstanding);
            fail_count++;
        end

endmodule

bind spu_top spu_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .i_cmd_valid  (i_cmd_valid),
    .o_cmd_credit (o_cmd_credit),
    .o_rsp_valid  (o_rsp_valid),
    .i_rsp_credit (i_rsp_credit)
);

// File: bench/spu_tb.sv
`timescale 1ns/1ps

module spu_tb import spu_pkg::*; ();

    localparam int TOTAL_CMDS     = 3500;               // All tests rounded up
    localparam int TIMEOUT_CYCLES = TOTAL_CMDS * 20 + 2 * 1024;

    logic     clk;
    logic     reset;
    logic     i_cmd_valid;
    spu_cmd_t i_cmd;
    logic     o_cmd_credit;
    logic     o_rsp_valid;
    spu_rsp_t o_rsp;
    logic     i_rsp_credit;

    spu_rsp_t exp_q [$];                                // Expected, in command order
    mr_data_t mr_sh [MR_WORDS];                         // Shadow modifier memory
    logic     inv_sh [NUM_PAGES];
    logic     ro_sh [NUM_PAGES];
    logic     pr_sh [NUM_PAGES];                        // Shadow reprioritize bits
    mr_grp_t  grp_sh;                                   // Shadow group register
    int       sent = 0;                                 // Commands driven
    int       credit_back = 0;                          // Credit pulses seen
    int       owed = 0;                                 // Responses not yet credited back
    int       hold_left;                                // Cycles left in a withheld window
    logic     hold_en = 1'b0;
    int       errors = 0;
    int       err_mark = 0;
    int       checks = 0;
    int       tests = 0;
    int       failed = 0;

    spu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                          // 4 ns period
    end

    initial begin
        #(TIMEOUT_CYCLES * 4);
        $display("Watchdog expired after %0d cycles, responses stopped", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------
    function automatic spu_rsp_t spu_model(input spu_cmd_t c);
        spu_rsp_t   r;
        logic [9:0] a;
        r = '{op: c.op, refused: 1'b0, data: '0};
        a = {grp_sh, c.idx};                            // Group selects the upper half
        if (c.from_instr && (c.op == MR_READ || c.op == MR_WRITE))
            r.refused = (c.idx >= 5'd16 && !c.priv) || (c.op == MR_WRITE && c.idx == 5'd0);
        if (!r.refused) begin
            case (c.op)
                MR_READ:    r.data = mr_sh[a];
                MR_WRITE:   mr_sh[a] = c.data;
                SET_GROUP:  grp_sh = c.data[4:0];
                PAGE_WRITE: {ro_sh[c.page], inv_sh[c.page]} = c.data[1:0];
                PAGE_READ:  r.data = {30'd0, ro_sh[c.page], inv_sh[c.page]};
                PRIO_WRITE: pr_sh[c.page] = c.data[0];
                PRIO_READ:  r.data = {31'd0, pr_sh[c.page]};
                PRIO_FILL:  for (int p = int'(c.page); p < NUM_PAGES; p++) pr_sh[p] = 1'b1;
                default:    r.data = '0;
            endcase
        end
        return r;
    endfunction

    function automatic spu_cmd_t make_cmd(input spu_op_t op, input logic priv,
            input logic from_instr, input mr_idx_t idx, input page_t page, input mr_data_t data);
        return '{op: op, priv: priv, from_instr: from_instr, idx: idx, page: page, data: data};
    endfunction

    function automatic mr_data_t fill_word(input logic [9:0] a);
        return {a, ~a, a ^ 10'h2a5, ^a, a[0]};          // Every bit of address matters
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("MISMATCH %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic send_cmd(input spu_cmd_t c);
        @(posedge clk);
        while (sent - credit_back >= CMD_CREDITS) begin  // Out of credits
            i_cmd_valid <= 1'b0;
            @(posedge clk);
        end
        i_cmd_valid <= 1'b1;
        i_cmd       <= c;
        sent++;
        exp_q.push_back(spu_model(c));
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        i_cmd_valid <= 1'b0;
        while (exp_q.size() != 0)                       // Drain under the watchdog
            @(posedge clk);
        tests++;
        failed += (errors != err_mark) ? 1 : 0;
        $display("TEST %-10s %s (%0d errors)", name,
            (errors == err_mark) ? "ok" : "FAILED", errors - err_mark);
        err_mark = errors;
    endtask

    // ------------------------------------------------------------
    // Credit tracking, response receiver and comparison
    // ------------------------------------------------------------
    always @(negedge clk) begin
        spu_rsp_t want;
        if (!reset && o_cmd_credit)
            credit_back++;
        if (!reset && o_rsp_valid) begin
            owed++;
            if (owed > RSP_CREDITS) begin
                $display("Receiver holds %0d unreturned responses, only %0d credits granted",
                    owed, RSP_CREDITS);
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("Response arrived with no command outstanding");
                errors++;
            end else begin
                want = exp_q.pop_front();
                check("o_rsp.op", 32'(o_rsp.op), 32'(want.op));
                check("o_rsp.refused", 32'(o_rsp.refused), 32'(want.refused));
                check("o_rsp.data", o_rsp.data, want.data);
            end
        end
    end

    initial begin
        i_rsp_credit = 1'b0;
        hold_left    = 0;
        forever begin
            @(posedge clk);
            if (hold_left > 0)
                hold_left--;
            else if (hold_en && $urandom_range(0, 15) == 0)
                hold_left = $urandom_range(5, 30);      // Start a withheld window
            if (owed > 0 && hold_left == 0) begin
                i_rsp_credit <= 1'b1;
                owed--;
            end else begin
                i_rsp_credit <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        page_t    pg [24];
        mr_idx_t  ix [4];
        page_t    fill_start;
        spu_cmd_t c;
        reset       = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        grp_sh      = '0;
        void'($urandom(46730));
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Known contents everywhere before any read
        for (int g = 0; g < 32; g++) begin
            send_cmd(make_cmd(SET_GROUP, 1'b0, 1'b0, '0, '0, mr_data_t'(g)));
            for (int i = 0; i < 32; i++)
                send_cmd(make_cmd(MR_WRITE, 1'b0, 1'b0, mr_idx_t'(i), '0,
                    fill_word(10'(g * 32 + i))));
        end
        for (int p = 0; p < NUM_PAGES; p++) begin
            send_cmd(make_cmd(PAGE_WRITE, 1'b0, 1'b0, '0, page_t'(p),
                {30'd0, ^(page_t'(p) & 10'h2b6), ^(page_t'(p))}));
            send_cmd(make_cmd(PRIO_WRITE, 1'b0, 1'b0, '0, page_t'(p), {31'd0, ~^(page_t'(p))}));
        end
        finish_test("preload");

        for (int k = 0; k < 6; k++) begin               // Microinstruction field in random groups
            send_cmd(make_cmd(SET_GROUP, 1'b0, 1'b0, '0, '0, mr_data_t'($urandom_range(0, 31))));
            for (int j = 0; j < 4; j++) begin
                ix[j] = mr_idx_t'(j * 8 + $urandom_range(0, 7));    // Distinct slots
                send_cmd(make_cmd(MR_WRITE, 1'b0, 1'b0, ix[j], '0, $urandom));
            end
            for (int j = 0; j < 4; j++)
                send_cmd(make_cmd(MR_READ, 1'b0, 1'b0, ix[j], '0, '0));
        end
        finish_test("roundtrip");

        send_cmd(make_cmd(SET_GROUP, 1'b0, 1'b0, '0, '0, 32'd9));
        send_cmd(make_cmd(MR_WRITE, 1'b1, 1'b1, 5'd0, '0, 32'hdead_beef));   // Index 0 locked
        send_cmd(make_cmd(MR_READ, 1'b0, 1'b0, 5'd0, '0, '0));
        send_cmd(make_cmd(MR_WRITE, 1'b0, 1'b1, 5'd20, '0, 32'h1234_5678));  // Upper half without priv
        send_cmd(make_cmd(MR_READ, 1'b0, 1'b1, 5'd20, '0, '0));
        send_cmd(make_cmd(MR_READ, 1'b0, 1'b0, 5'd20, '0, '0));             // Old value kept
        send_cmd(make_cmd(MR_WRITE, 1'b1, 1'b1, 5'd20, '0, 32'h0bad_cafe));
        send_cmd(make_cmd(MR_READ, 1'b1, 1'b1, 5'd20, '0, '0));
        send_cmd(make_cmd(MR_WRITE, 1'b0, 1'b1, 5'd5, '0, 32'h5555_aaaa));   // Lower half open
        send_cmd(make_cmd(MR_READ, 1'b0, 1'b1, 5'd5, '0, '0));
        send_cmd(make_cmd(MR_WRITE, 1'b0, 1'b0, 5'd0, '0, 32'hfeed_f00d));   // Micro field exempt
        send_cmd(make_cmd(MR_READ, 1'b0, 1'b0, 5'd0, '0, '0));
        send_cmd(make_cmd(MR_WRITE, 1'b0, 1'b0, 5'd31, '0, 32'h3131_3131));
        send_cmd(make_cmd(MR_READ, 1'b0, 1'b1, 5'd31, '0, '0));
        send_cmd(make_cmd(MR_READ, 1'b0, 1'b0, 5'd31, '0, '0));
        finish_test("privilege");

        for (int n = 0; n < 24; n++) begin
            pg[n] = page_t'($urandom_range(0, NUM_PAGES - 1));
            send_cmd(make_cmd(PAGE_WRITE, 1'b0, 1'b1, '0, pg[n], mr_data_t'($urandom_range(0, 3))));
            send_cmd(make_cmd(PRIO_WRITE, 1'b1, 1'b1, '0, pg[n], mr_data_t'($urandom_range(0, 1))));
        end
        for (int n = 0; n < 24; n++) begin
            send_cmd(make_cmd(PAGE_READ, 1'b0, 1'b0, '0, pg[n], '0));
            send_cmd(make_cmd(PRIO_READ, 1'b0, 1'b0, '0, pg[n], '0));
        end
        finish_test("pagebits");

        fill_start = page_t'($urandom_range(600, 1000));
        for (int n = 1; n <= 3; n++)                    // Below the start and must survive
            send_cmd(make_cmd(PRIO_WRITE, 1'b0, 1'b0, '0, page_t'(fill_start - n),
                mr_data_t'(n % 2)));
        send_cmd(make_cmd(PRIO_WRITE, 1'b0, 1'b0, '0, fill_start, '0));
        send_cmd(make_cmd(PRIO_WRITE, 1'b0, 1'b0, '0, LAST_PAGE, '0));
        send_cmd(make_cmd(PRIO_FILL, 1'b0, 1'b0, '0, fill_start, '0));
        send_cmd(make_cmd(MR_READ, 1'b0, 1'b0, 5'd3, '0, '0));     // Must answer after fill
        for (int n = -3; n <= 3; n++)
            send_cmd(make_cmd(PRIO_READ, 1'b0, 1'b0, '0, page_t'(fill_start + n), '0));
        send_cmd(make_cmd(PRIO_READ, 1'b0, 1'b0, '0, LAST_PAGE, '0));
        for (int n = 0; n < 8; n++)
            send_cmd(make_cmd(PRIO_READ, 1'b0, 1'b0, '0, page_t'($urandom), '0));
        finish_test("fill");

        hold_en = 1'b1;                                 // Receiver withholds credits
        for (int n = 0; n < 200; n++) begin
            c.op         = spu_op_t'($urandom_range(0, 7));
            c.priv       = 1'($urandom_range(0, 1));
            c.from_instr = 1'($urandom_range(0, 1));
            c.idx        = mr_idx_t'($urandom);
            c.page       = (c.op == PRIO_FILL) ? page_t'($urandom_range(1000, NUM_PAGES - 1))
                                               : page_t'($urandom);     // Short fills only
            c.data       = $urandom;
            send_cmd(c);
        end
        finish_test("backpress");
        hold_en = 1'b0;

        check("o_cmd_credit pulses", credit_back, sent);
        $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
            tests, failed, checks, errors, DUT.u_asserts.fail_count);
        if (errors == 0 && DUT.u_asserts.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: besm_spu.f
source/spu_pkg.sv
source/spu_decode.sv
source/spu_access.sv
source/spu_respond.sv
source/spu_top.sv
bench/spu_asserts.sv
bench/spu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the SPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module spu_tb -Mdir obj_dir -o spu_sim -f besm_spu.f > "$BUILD_LOG" 2>&1; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/spu_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" "$SIM_LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1

// File: source/spu_access.sv
`timescale 1ns/1ps

module spu_access import spu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     i_acc_valid,
    input  spu_acc_t i_acc,
    output logic     o_acc_ready,
    output logic     o_rsp_push,                        // One per accepted item
    output spu_rsp_t o_rsp,
    input  logic     i_rsp_slots_free                   // Room for one more response
);

    mr_data_t mr_mem    [MR_WORDS];                     // Modifier registers
    logic     pg_inv    [NUM_PAGES];                    // Access invalid bits
    logic     pg_ro     [NUM_PAGES];                    // Read-only bits
    logic     pg_reprio [NUM_PAGES];                    // Reprioritize requests
    logic     take;                                     // Item accepted
    logic     do_op;                                    // Accepted and allowed
    logic     fill_busy;                                // Fill engine running
    page_t    fill_page;                                // Page being set
    mr_data_t rd_data;                                  // Read result

    assign o_acc_ready = !fill_busy && i_rsp_slots_free;
    assign take        = i_acc_valid && o_acc_ready;
    assign do_op       = take && !i_acc.refused;

    // ------------------------------------------------------------
    // Modifier and protection memories
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_op) begin
            case (i_acc.op)
                MR_WRITE: mr_mem[i_acc.mr_addr] <= i_acc.data;
                PAGE_WRITE: begin
                    pg_inv[i_acc.page] <= i_acc.data[0];
                    pg_ro[i_acc.page]  <= i_acc.data[1];
                end
                default: ;
            endcase
        end
    end

    // Fill wins over reprioritize writes
    always_ff @(posedge clk) begin
        if (fill_busy)
            pg_reprio[fill_page] <= 1'b1;               // One page per cycle
        else if (do_op && i_acc.op == PRIO_WRITE)
            pg_reprio[i_acc.page] <= i_acc.data[0];
    end

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    always_comb begin
        rd_data = '0;                                   // Writes answer with zero
        case (i_acc.op)
            MR_READ:   rd_data = mr_mem[i_acc.mr_addr];
            PAGE_READ: rd_data = {30'd0, pg_ro[i_acc.page], pg_inv[i_acc.page]};
            PRIO_READ: rd_data = {31'd0, pg_reprio[i_acc.page]};
            default:   rd_data = '0;
        endcase
    end

    // Response payload held through a fill
    always_ff @(posedge clk) begin
        if (take) begin
            o_rsp.op      <= i_acc.op;
            o_rsp.refused <= i_acc.refused;
            o_rsp.data    <= i_acc.refused ? '0 : rd_data;   // Refused passes empty
        end
    end

    // ------------------------------------------------------------
    // Fill engine and push control
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_busy  <= 1'b0;
            fill_page  <= '0;
            o_rsp_push <= 1'b0;
        end else begin
            o_rsp_push <= 1'b0;                         // Single-cycle push
            if (fill_busy) begin
                if (fill_page == LAST_PAGE) begin
                    fill_busy  <= 1'b0;                 // Whole range set
                    o_rsp_push <= 1'b1;                 // Fill answers on completion
                end else begin
                    fill_page <= fill_page + 1'b1;
                end
            end else if (do_op && i_acc.op == PRIO_FILL) begin
                fill_busy <= 1'b1;
                fill_page <= i_acc.page;                // Start page
            end else if (take) begin
                o_rsp_push <= 1'b1;
            end
        end
    end

endmodule

// File: source/spu_decode.sv
`timescale 1ns/1ps

module spu_decode import spu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     i_cmd_valid,                       // Sender holds a credit
    input  spu_cmd_t i_cmd,
    output logic     o_cmd_credit,                      // One pulse per popped command
    output logic     o_acc_valid,
    output spu_acc_t o_acc,
    input  logic     i_acc_ready                        // Low during fill or full responses
);

    spu_cmd_t             cmd_mem [CMD_CREDITS];        // Command queue storage
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_CNT_W-1:0] cmd_count;                    // Entries held
    spu_cmd_t             head;                         // Oldest command
    mr_grp_t              group;                        // Group number register
    logic                 pop;                          // Head moves to access
    logic                 in_upper;                     // Index 16 to 31
    logic                 refused;

    // ------------------------------------------------------------
    // Command queue
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_cmd_valid)
            cmd_mem[wr_ptr] <= i_cmd;                   // Credits keep it from overflowing
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            cmd_count    <= '0;
            o_cmd_credit <= 1'b0;
        end else begin
            if (i_cmd_valid)
                wr_ptr <= (wr_ptr == CMD_PTR_W'(CMD_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == CMD_PTR_W'(CMD_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            cmd_count    <= cmd_count + CMD_CNT_W'(i_cmd_valid) - CMD_CNT_W'(pop);
            o_cmd_credit <= pop;                        // Give the freed slot back
        end
    end

    assign head        = cmd_mem[rd_ptr];
    assign o_acc_valid = (cmd_count != '0);             // Head is presented directly
    assign pop         = o_acc_valid && i_acc_ready;

    // ------------------------------------------------------------
    // Group register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            group <= '0;
        else if (pop && head.op == SET_GROUP)
            group <= mr_grp_t'(head.data);              // Low bits of data
    end

    // ------------------------------------------------------------
    // Privilege rules
    // ------------------------------------------------------------
    assign in_upper = head.idx[4];

    // Microinstruction-field commands are exempt
    always_comb begin
        refused = 1'b0;
        if (head.from_instr) begin
            case (head.op)
                MR_WRITE: refused = (head.idx == '0) || (in_upper && !head.priv);
                MR_READ:  refused = in_upper && !head.priv;
                default:  refused = 1'b0;
            endcase
        end
    end

    // Item for access stage
    assign o_acc = '{
        op:      head.op,
        refused: refused,
        mr_addr: '{grp: group, idx: head.idx},          // Group set by earlier cmds
        page:    head.page,
        data:    head.data
    };

endmodule

// File: source/spu_pkg.sv
package spu_pkg;

    // ------------------------------------------------------------
    // Depths and derived widths
    // ------------------------------------------------------------
    localparam int CMD_CREDITS = 4;                     // Command queue depth, sender credit
    localparam int RSP_CREDITS = 4;                     // Receiver credit after reset
    localparam int RSP_DEPTH   = 4;                     // Response queue depth
    localparam int MR_WORDS    = 1024;                  // 32 groups of 32 modifiers
    localparam int NUM_PAGES   = 1024;                  // Physical pages

    localparam int CMD_PTR_W  = $clog2(CMD_CREDITS);
    localparam int CMD_CNT_W  = $clog2(CMD_CREDITS + 1);
    localparam int RSP_PTR_W  = $clog2(RSP_DEPTH);
    localparam int RSP_CNT_W  = $clog2(RSP_DEPTH + 1);
    localparam int RSP_CRED_W = $clog2(RSP_CREDITS + 1);

    // ------------------------------------------------------------
    // Scalar types
    // ------------------------------------------------------------
    typedef logic [31:0] mr_data_t;                     // Modifier register value
    typedef logic [4:0]  mr_idx_t;                      // Index within a group
    typedef logic [4:0]  mr_grp_t;                      // Group number
    typedef logic [9:0]  page_t;                        // Physical page number

    localparam page_t LAST_PAGE = page_t'(NUM_PAGES - 1);   // Fill stops here

    typedef enum logic [2:0] {
        MR_READ    = 3'd0,                              // Read modifier
        MR_WRITE   = 3'd1,                              // Write modifier
        SET_GROUP  = 3'd2,                              // Load group register
        PAGE_WRITE = 3'd3,                              // Bit 0 invalid, bit 1 read-only
        PAGE_READ  = 3'd4,
        PRIO_WRITE = 3'd5,                              // Reprioritize bit in data[0]
        PRIO_READ  = 3'd6,
        PRIO_FILL  = 3'd7                               // Ones from page up to the top
    } spu_op_t;

    // ------------------------------------------------------------
    // Packed records between the stages
    // ------------------------------------------------------------
    typedef struct packed {
        mr_grp_t grp;                                   // Upper half of address
        mr_idx_t idx;
    } mr_addr_t;

    typedef struct packed {
        spu_op_t  op;
        logic     priv;                                 // Privileged access flag
        logic     from_instr;                           // Index from instruction field
        mr_idx_t  idx;
        page_t    page;
        mr_data_t data;
    } spu_cmd_t;

    typedef struct packed {
        spu_op_t  op;
        logic     refused;                              // Stopped by privilege rules
        mr_data_t data;
    } spu_rsp_t;

    typedef struct packed {
        spu_op_t  op;
        logic     refused;
        mr_addr_t mr_addr;                              // Group and index
        page_t    page;
        mr_data_t data;
    } spu_acc_t;

endpackage

// File: source/spu_respond.sv
`timescale 1ns/1ps

module spu_respond import spu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     i_rsp_push,
    input  spu_rsp_t i_rsp,
    output logic     o_rsp_slots_free,                  // Access may take one item
    output logic     o_rsp_valid,
    output spu_rsp_t o_rsp,
    input  logic     i_rsp_credit                       // One credit back per pulse
);

    spu_rsp_t              rsp_mem [RSP_DEPTH];         // Response queue storage
    logic [RSP_PTR_W-1:0]  wr_ptr;
    logic [RSP_PTR_W-1:0]  rd_ptr;
    logic [RSP_CNT_W-1:0]  rsp_count;                   // Entries held
    logic [RSP_CRED_W-1:0] credits;                     // Receiver credits held

    // ------------------------------------------------------------
    // Response queue
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rsp_push)
            rsp_mem[wr_ptr] <= i_rsp;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            rsp_count <= '0;
        end else begin
            if (i_rsp_push)
                wr_ptr <= (wr_ptr == RSP_PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (o_rsp_valid)
                rd_ptr <= (rd_ptr == RSP_PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            rsp_count <= rsp_count + RSP_CNT_W'(i_rsp_push) - RSP_CNT_W'(o_rsp_valid);
        end
    end

    // Item being pushed counts as taken while pops are ignored
    assign o_rsp_slots_free =
        (rsp_count + RSP_CNT_W'(i_rsp_push)) < RSP_CNT_W'(RSP_DEPTH);

    // ------------------------------------------------------------
    // Output credits
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            credits <= RSP_CRED_W'(RSP_CREDITS);        // Receiver buffer is empty
        else
            credits <= credits - RSP_CRED_W'(o_rsp_valid) + RSP_CRED_W'(i_rsp_credit);
    end

    assign o_rsp_valid = (rsp_count != '0) && (credits != '0);   // Spend one per send
    assign o_rsp       = rsp_mem[rd_ptr];

endmodule

// File: source/spu_top.sv
`timescale 1ns/1ps

module spu_top import spu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     i_cmd_valid,
    input  spu_cmd_t i_cmd,
    output logic     o_cmd_credit,
    output logic     o_rsp_valid,
    output spu_rsp_t o_rsp,
    input  logic     i_rsp_credit
);

    logic     acc_valid;                                // Decode to access
    spu_acc_t acc;
    logic     acc_ready;
    logic     rsp_push;                                 // Access to respond
    spu_rsp_t rsp;
    logic     rsp_slots_free;

    // ------------------------------------------------------------
    // Three-stage pipeline
    // ------------------------------------------------------------
    spu_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (i_cmd),
        .o_cmd_credit (o_cmd_credit),
        .o_acc_valid  (acc_valid),
        .o_acc        (acc),
        .i_acc_ready  (acc_ready)
    );

    spu_access u_access (
        .clk              (clk),
        .reset            (reset),
        .i_acc_valid      (acc_valid),
        .i_acc            (acc),
        .o_acc_ready      (acc_ready),
        .o_rsp_push       (rsp_push),
        .o_rsp            (rsp),
        .i_rsp_slots_free (rsp_slots_free)
    );

    spu_respond u_respond (
        .clk              (clk),
        .reset            (reset),
        .i_rsp_push       (rsp_push),
        .i_rsp            (rsp),
        .o_rsp_slots_free (rsp_slots_free),
        .o_rsp_valid      (o_rsp_valid),
        .o_rsp            (o_rsp),
        .i_rsp_credit     (i_rsp_credit)
    );

endmodule
